// File: spi_link_pkg.sv
package spi_link_pkg;

   // byte counter saturates at its top value
   localparam int BYTE_CNT_W = 8;
   localparam int BIT_CNT_W  = 3;

   // strobes and levels from the SPI slave to the command decoder
   typedef struct packed {
      logic                  cmd_ready;
      logic                  param_ready;
      logic [7:0]            cmd_data;
      logic [7:0]            param_data;
      logic [BYTE_CNT_W-1:0] byte_cnt;
      logic [BIT_CNT_W-1:0]  bit_cnt;
   } spi_rx_t;

endpackage

// File: cart_pkg.sv
package cart_pkg;

   //////////////////////////////////////////////////////////////////////
   // command opcodes
   //////////////////////////////////////////////////////////////////////

   // high nibble commands
   localparam logic [3:0] CMD_SET_ADDR  = 4'h0;
   localparam logic [3:0] CMD_ROM_MASK  = 4'h1;
   localparam logic [3:0] CMD_SRAM_MASK = 4'h2;
   localparam logic [3:0] CMD_MAPPER    = 4'h3;
   localparam logic [3:0] CMD_READ      = 4'h8;
   localparam logic [3:0] CMD_WRITE     = 4'h9;

   // full byte commands
   localparam logic [7:0] CMD_MSU_STATUS = 8'hE0;
   localparam logic [7:0] CMD_DAC_PAUSE  = 8'hE1;
   localparam logic [7:0] CMD_DAC_PLAY   = 8'hE2;
   localparam logic [7:0] CMD_DAC_RESET  = 8'hE3;
   localparam logic [7:0] CMD_ECHO       = 8'hF0;
   localparam logic [7:0] CMD_STATUS     = 8'hF1;
   localparam logic [7:0] CMD_SYSCLK     = 8'hFE;
   localparam logic [7:0] CMD_PARAM_ECHO = 8'hFF;

   // set address target, low bits of the command
   localparam logic [1:0] ADDR_TGT_DAC = 2'b01;
   localparam logic [1:0] ADDR_TGT_MSU = 2'b10;

   // read/write command bit for address auto-increment
   localparam int AUTO_INC_BIT = 3;

   localparam logic [7:0] ECHO_BYTE = 8'hA5;

   //////////////////////////////////////////////////////////////////////
   // frequency meter
   //////////////////////////////////////////////////////////////////////

   localparam int FREQ_WINDOW = 2048;
   localparam int FREQ_WIN_W  = $clog2(FREQ_WINDOW);
   localparam int FREQ_W      = 32;
   localparam logic [FREQ_WIN_W-1:0] FREQ_WIN_LAST = FREQ_WIN_W'(FREQ_WINDOW - 1);

   typedef struct packed {
      logic [3:0]  mapper;
      logic [23:0] rom_mask;
      logic [23:0] saveram_mask;
   } cart_cfg_t;

   typedef struct packed {
      logic [23:0] addr;
      logic [7:0]  wdata;
      logic        rd_n;
      logic        wr_n;
   } mem_bus_t;

   typedef struct packed {
      logic [10:0] dac_addr;
      logic        dac_play;
      logic        dac_reset;
      logic [13:0] msu_addr;
      logic [5:0]  msu_status_set;
      logic [5:0]  msu_status_reset;
      logic        msu_status_we;
   } audio_ctrl_t;

   typedef struct packed {
      logic       dac_busy;
      logic [6:0] msu_status;
   } cart_status_t;

endpackage

// File: spi_slave.sv
`timescale 1ns/10ps

module spi_slave (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  sck,
   input  logic                  mosi,
   input  logic                  ncs,
   output logic                  miso,
   input  logic [7:0]            spi_reply,
   output spi_link_pkg::spi_rx_t rx
);

   // two sync stages, sck has a third for edge detection
   logic [2:0] sck_r;
   logic [1:0] mosi_r;
   logic [1:0] ncs_r;
   logic       sck_rise;
   logic       sck_fall;
   logic       frame_idle;

   logic [spi_link_pkg::BIT_CNT_W-1:0]  bit_cnt;
   logic [spi_link_pkg::BYTE_CNT_W-1:0] byte_cnt;
   logic                                cmd_ready;
   logic                                param_ready;
   logic [7:0]                          cmd_data;
   logic [7:0]                          param_data;
   logic [6:0]                          rx_shift;
   logic [7:0]                          rx_byte;
   logic [7:0]                          tx_shift;

   always_ff @(posedge clk) begin
      if (reset) begin
         sck_r  <= '0;
         mosi_r <= '0;
         ncs_r  <= '1;
      end else begin
         sck_r  <= {sck_r[1:0], sck};
         mosi_r <= {mosi_r[0], mosi};
         ncs_r  <= {ncs_r[0], ncs};
      end
   end

   assign sck_rise   = (sck_r[2:1] == 2'b01);
   assign sck_fall   = (sck_r[2:1] == 2'b10);
   assign frame_idle = ncs_r[1];

   // msb first, last bit taken straight from the sync stage
   assign rx_byte = {rx_shift, mosi_r[1]};

   always_ff @(posedge clk) begin
      if (sck_rise) begin
         rx_shift <= rx_byte[6:0];
      end
   end

   //////////////////////////////////////////////////////////////////////
   // bit and byte counting
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         bit_cnt     <= '0;
         byte_cnt    <= '0;
         cmd_ready   <= 1'b0;
         param_ready <= 1'b0;
         cmd_data    <= '0;
         param_data  <= '0;
      end else begin
         cmd_ready   <= 1'b0;
         param_ready <= 1'b0;
         if (frame_idle) begin
            bit_cnt  <= '0;
            byte_cnt <= '0;
         end else if (sck_rise) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
               if (byte_cnt != '1) begin
                  byte_cnt <= byte_cnt + 1'b1;
               end
               // first byte of the frame is the command
               if (byte_cnt == '0) begin
                  cmd_ready <= 1'b1;
                  cmd_data  <= rx_byte;
               end else begin
                  param_ready <= 1'b1;
                  param_data  <= rx_byte;
               end
            end
         end
      end
   end

   // reply loaded on the fall right after a byte ends
   always_ff @(posedge clk) begin
      if (reset || frame_idle) begin
         tx_shift <= '0;
      end else if (sck_fall) begin
         if (bit_cnt == '0) begin
            tx_shift <= spi_reply;
         end else begin
            tx_shift <= {tx_shift[6:0], 1'b0};
         end
      end
   end

   assign miso = tx_shift[7];

   assign rx = '{cmd_ready:   cmd_ready,
                 param_ready: param_ready,
                 cmd_data:    cmd_data,
                 param_data:  param_data,
                 byte_cnt:    byte_cnt,
                 bit_cnt:     bit_cnt};

endmodule

// File: clk_freq_meter.sv
`timescale 1ns/10ps

module clk_freq_meter (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        sysclk,
   output logic [cart_pkg::FREQ_W-1:0] freq
);

   logic [2:0]                      sysclk_r;
   logic                            sysclk_rise;
   logic [cart_pkg::FREQ_WIN_W-1:0] win_cnt;
   logic [cart_pkg::FREQ_W-1:0]     edge_cnt;
   logic                            win_end;

   always_ff @(posedge clk) begin
      if (reset) begin
         sysclk_r <= '0;
      end else begin
         sysclk_r <= {sysclk_r[1:0], sysclk};
      end
   end

   assign sysclk_rise = (sysclk_r[2:1] == 2'b01);
   assign win_end     = (win_cnt == cart_pkg::FREQ_WIN_LAST);

   // count edges per window, last window's total held in freq
   always_ff @(posedge clk) begin
      if (reset) begin
         win_cnt  <= '0;
         edge_cnt <= '0;
         freq     <= '0;
      end else if (win_end) begin
         win_cnt  <= '0;
         edge_cnt <= '0;
         freq     <= sysclk_rise ? edge_cnt + 1'b1 : edge_cnt;
      end else begin
         win_cnt <= win_cnt + 1'b1;
         if (sysclk_rise) begin
            edge_cnt <= edge_cnt + 1'b1;
         end
      end
   end

endmodule

// File: mcu_cmd.sv
`timescale 1ns/10ps

module mcu_cmd (
   input  logic                         clk,
   input  logic                         reset,
   input  spi_link_pkg::spi_rx_t        rx,
   output logic [7:0]                   spi_reply,
   input  logic [cart_pkg::FREQ_W-1:0]  sysclk_freq,
   input  cart_pkg::cart_status_t       status,
   input  logic [7:0]                   mem_rdata,
   output cart_pkg::mem_bus_t           mem,
   output cart_pkg::cart_cfg_t          cfg,
   output cart_pkg::audio_ctrl_t        audio
);

   logic [3:0]  cmd_hi;
   logic        auto_inc;

   logic [3:0]  mapper_q;
   logic [23:0] rom_mask_q;
   logic [23:0] sram_mask_q;
   logic [23:0] addr_q;
   logic [10:0] dac_addr_q;
   logic [13:0] msu_addr_q;
   logic        dac_play_q;
   logic        dac_reset_q;
   logic        msu_we_q;
   logic        rd_n_q;
   logic        wr_n_q;

   logic [7:0]                  wdata_q;
   logic [5:0]                  msu_set_q;
   logic [5:0]                  msu_reset_q;
   logic [cart_pkg::FREQ_W-1:0] freq_snap;
   cart_pkg::cart_status_t      status_q;
   logic [7:0]                  reply_q;

   assign cmd_hi = rx.cmd_data[7:4];

   // reads step after byte 1, writes one byte later
   assign auto_inc = (cmd_hi == cart_pkg::CMD_READ || cmd_hi == cart_pkg::CMD_WRITE) &&
                     rx.cmd_data[cart_pkg::AUTO_INC_BIT] &&
                     (rx.byte_cnt > (8'd1 + {7'd0, rx.cmd_data[4]}));

   //////////////////////////////////////////////////////////////////////
   // configuration, pointers and audio control
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         mapper_q    <= '0;
         rom_mask_q  <= '0;
         sram_mask_q <= '0;
         addr_q      <= '0;
         dac_addr_q  <= '0;
         msu_addr_q  <= '0;
         dac_play_q  <= 1'b0;
         dac_reset_q <= 1'b0;
         msu_we_q    <= 1'b0;
      end else begin
         dac_reset_q <= 1'b0;
         msu_we_q    <= 1'b0;
         if (rx.cmd_ready) begin
            if (cmd_hi == cart_pkg::CMD_MAPPER) begin
               mapper_q <= rx.cmd_data[3:0];
            end
         end else if (rx.param_ready) begin
            case (cmd_hi)
               cart_pkg::CMD_SET_ADDR: begin
                  if (rx.cmd_data[1:0] == cart_pkg::ADDR_TGT_DAC) begin
                     if (rx.byte_cnt == 8'd2) begin
                        dac_addr_q <= {rx.param_data[2:0], 8'h00};
                     end else if (rx.byte_cnt == 8'd3) begin
                        dac_addr_q[7:0] <= rx.param_data;
                     end
                  end else if (rx.cmd_data[1:0] == cart_pkg::ADDR_TGT_MSU) begin
                     if (rx.byte_cnt == 8'd2) begin
                        msu_addr_q <= {rx.param_data[5:0], 8'h00};
                     end else if (rx.byte_cnt == 8'd3) begin
                        msu_addr_q[7:0] <= rx.param_data;
                     end
                  end else begin
                     // memory address, high byte first
                     case (rx.byte_cnt)
                        8'd2:    addr_q <= {rx.param_data, 16'h0000};
                        8'd3:    addr_q[15:8] <= rx.param_data;
                        8'd4:    addr_q[7:0] <= rx.param_data;
                        default: ;
                     endcase
                  end
               end
               cart_pkg::CMD_ROM_MASK: begin
                  case (rx.byte_cnt)
                     8'd2:    rom_mask_q[23:16] <= rx.param_data;
                     8'd3:    rom_mask_q[15:8] <= rx.param_data;
                     8'd4:    rom_mask_q[7:0] <= rx.param_data;
                     default: ;
                  endcase
               end
               cart_pkg::CMD_SRAM_MASK: begin
                  case (rx.byte_cnt)
                     8'd2:    sram_mask_q[23:16] <= rx.param_data;
                     8'd3:    sram_mask_q[15:8] <= rx.param_data;
                     8'd4:    sram_mask_q[7:0] <= rx.param_data;
                     default: ;
                  endcase
               end
               default: ;
            endcase

            case (rx.cmd_data)
               cart_pkg::CMD_MSU_STATUS: msu_we_q <= (rx.byte_cnt == 8'd3);
               cart_pkg::CMD_DAC_PAUSE:  dac_play_q <= 1'b0;
               cart_pkg::CMD_DAC_PLAY:   dac_play_q <= 1'b1;
               cart_pkg::CMD_DAC_RESET:  dac_reset_q <= (rx.byte_cnt == 8'd2);
               default: ;
            endcase

            if (auto_inc) begin
               addr_q <= addr_q + 24'd1;
            end
         end
      end
   end

   // write strobe early in the byte after capture, read late in the byte
   always_ff @(posedge clk) begin
      if (reset) begin
         rd_n_q <= 1'b1;
         wr_n_q <= 1'b1;
      end else begin
         rd_n_q <= !((cmd_hi == cart_pkg::CMD_READ) && (rx.bit_cnt >= 3'd5) &&
                     (rx.byte_cnt != '0));
         wr_n_q <= !((cmd_hi == cart_pkg::CMD_WRITE) && (rx.bit_cnt >= 3'd1) &&
                     (rx.bit_cnt <= 3'd3) && (rx.byte_cnt > 8'd1));
      end
   end

   always_ff @(posedge clk) begin
      status_q <= status;
      if (rx.param_ready) begin
         if (cmd_hi == cart_pkg::CMD_WRITE) begin
            wdata_q <= rx.param_data;
         end
         if (rx.cmd_data == cart_pkg::CMD_MSU_STATUS) begin
            if (rx.byte_cnt == 8'd2) begin
               msu_set_q <= rx.param_data[5:0];
            end else if (rx.byte_cnt == 8'd3) begin
               msu_reset_q <= rx.param_data[5:0];
            end
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // reply byte, fetched during the last bit
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rx.bit_cnt == 3'd7) begin
         if (rx.cmd_data == cart_pkg::CMD_ECHO) begin
            reply_q <= cart_pkg::ECHO_BYTE;
         end else if (rx.cmd_data == cart_pkg::CMD_STATUS) begin
            if (rx.byte_cnt[0]) begin
               reply_q <= {status_q.dac_busy, status_q.msu_status[6], 6'b0};
            end else begin
               reply_q <= {2'b0, status_q.msu_status[5:0]};
            end
         end else if (rx.cmd_data == cart_pkg::CMD_SYSCLK) begin
            // snapshot first so the four bytes agree
            case (rx.byte_cnt)
               8'd1: begin
                  freq_snap <= sysclk_freq;
                  reply_q   <= '0;
               end
               8'd2:    reply_q <= freq_snap[31:24];
               8'd3:    reply_q <= freq_snap[23:16];
               8'd4:    reply_q <= freq_snap[15:8];
               8'd5:    reply_q <= freq_snap[7:0];
               default: reply_q <= '0;
            endcase
         end else if (rx.cmd_data == cart_pkg::CMD_PARAM_ECHO) begin
            reply_q <= rx.param_data;
         end else if (cmd_hi == cart_pkg::CMD_READ) begin
            reply_q <= mem_rdata;
         end else begin
            reply_q <= rx.cmd_data;
         end
      end
   end

   assign spi_reply = reply_q;

   assign mem = '{addr: addr_q, wdata: wdata_q, rd_n: rd_n_q, wr_n: wr_n_q};

   assign cfg = '{mapper: mapper_q, rom_mask: rom_mask_q, saveram_mask: sram_mask_q};

   assign audio = '{dac_addr:         dac_addr_q,
                    dac_play:         dac_play_q,
                    dac_reset:        dac_reset_q,
                    msu_addr:         msu_addr_q,
                    msu_status_set:   msu_set_q,
                    msu_status_reset: msu_reset_q,
                    msu_status_we:    msu_we_q};

endmodule

// File: cart_ctrl_top.sv
`timescale 1ns/10ps

module cart_ctrl_top (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   sck,
   input  logic                   mosi,
   input  logic                   ncs,
   output logic                   miso,
   input  logic                   sysclk,
   input  logic [7:0]             mem_rdata,
   input  cart_pkg::cart_status_t status,
   output cart_pkg::mem_bus_t     mem,
   output cart_pkg::cart_cfg_t    cfg,
   output cart_pkg::audio_ctrl_t  audio
);

   spi_link_pkg::spi_rx_t       rx;
   logic [7:0]                  spi_reply;
   logic [cart_pkg::FREQ_W-1:0] sysclk_freq;

   // mcu link
   spi_slave u_spi_slave (
      .clk       (clk),
      .reset     (reset),
      .sck       (sck),
      .mosi      (mosi),
      .ncs       (ncs),
      .miso      (miso),
      .spi_reply (spi_reply),
      .rx        (rx)
   );

   // console clock measurement
   clk_freq_meter u_clk_freq_meter (
      .clk    (clk),
      .reset  (reset),
      .sysclk (sysclk),
      .freq   (sysclk_freq)
   );

   mcu_cmd u_mcu_cmd (
      .clk         (clk),
      .reset       (reset),
      .rx          (rx),
      .spi_reply   (spi_reply),
      .sysclk_freq (sysclk_freq),
      .status      (status),
      .mem_rdata   (mem_rdata),
      .mem         (mem),
      .cfg         (cfg),
      .audio       (audio)
   );

endmodule

// File: cart_ctrl_assertions.sv
`timescale 1ns/10ps

module cart_ctrl_assertions (
   input logic                  clk,
   input logic                  reset,
   input cart_pkg::mem_bus_t    mem,
   input cart_pkg::audio_ctrl_t audio
);

   // one byte at 16 clk per sck bit
   localparam int BYTE_CLKS = 128;

   int fail_count = 0;

   a_strobe_excl: assert property (@(posedge clk) disable iff (reset)
      !(!mem.rd_n && !mem.wr_n))
      else begin
         fail_count++;
         $error("rd_n and wr_n low together");
      end

   a_msu_we_short: assert property (@(posedge clk) disable iff (reset)
      $rose(audio.msu_status_we) |-> ##[1:BYTE_CLKS] !audio.msu_status_we)
      else begin
         fail_count++;
         $error("msu_status_we high for more than one byte time");
      end

   a_dac_reset_short: assert property (@(posedge clk) disable iff (reset)
      $rose(audio.dac_reset) |-> ##[1:BYTE_CLKS] !audio.dac_reset)
      else begin
         fail_count++;
         $error("dac_reset high for more than one byte time");
      end

   // strobes idle once reset has been seen
   a_reset_idle: assert property (@(posedge clk)
      reset |=> (mem.rd_n && mem.wr_n && !audio.dac_play && !audio.dac_reset &&
                 !audio.msu_status_we))
      else begin
         fail_count++;
         $error("strobe active after reset");
      end

endmodule

bind cart_ctrl_top cart_ctrl_assertions u_assertions (
   .clk   (clk),
   .reset (reset),
   .mem   (mem),
   .audio (audio)
);

// File: tb_cart_ctrl.sv
`timescale 1ns/10ps

module tb_cart_ctrl;

   localparam int CLK_PERIOD   = 100;
   localparam int RESET_CYCLES = 16;
   localparam int SCK_HALF     = 8;
   localparam int WR_BYTES     = 8;
   localparam int NUM_FRAMES   = 17;
   localparam int NUM_BYTES    = 75;
   localparam int FREQ_NOMINAL = cart_pkg::FREQ_WINDOW / 6;

   // 16 clk per bit for every byte plus two spare byte slots per frame and meter settling
   localparam longint WATCHDOG_NS =
      longint'(NUM_BYTES + 2 * NUM_FRAMES) * 16 * 8 * CLK_PERIOD +
      longint'(3 * cart_pkg::FREQ_WINDOW + RESET_CYCLES) * CLK_PERIOD;

   logic                   clk;
   logic                   reset;
   logic                   sck;
   logic                   mosi;
   logic                   ncs;
   logic                   miso;
   logic                   sysclk;
   logic [7:0]             mem_rdata;
   cart_pkg::cart_status_t status;
   cart_pkg::mem_bus_t     mem;
   cart_pkg::cart_cfg_t    cfg;
   cart_pkg::audio_ctrl_t  audio;

   logic [7:0]  tx_bytes [0:15];
   logic [7:0]  rx_bytes [0:15];
   logic [7:0]  mem_model [0:255];
   logic [7:0]  ref_mem [0:255];
   int          frame_len;
   string       test_name;
   event        frame_done;
   logic [31:0] lcg_state;
   logic [23:0] rd_base;
   logic [23:0] wr_base;
   logic        wr_active = 1'b0;
   int          wr_seen = 0;
   logic        rd_active = 1'b0;
   int          rd_seen = 0;
   int          dac_reset_pulses = 0;
   int          msu_we_pulses = 0;
   logic [5:0]  msu_set_seen;
   logic [5:0]  msu_reset_seen;
   logic        wr_n_prev = 1'b1;
   logic        rd_n_prev = 1'b1;
   logic        dac_reset_prev = 1'b0;
   logic        msu_we_prev = 1'b0;
   int          mismatch_count = 0;
   int          fault_count = 0;
   int          frame_count = 0;

   cart_ctrl_top dut (
      .clk       (clk),
      .reset     (reset),
      .sck       (sck),
      .mosi      (mosi),
      .ncs       (ncs),
      .miso      (miso),
      .sysclk    (sysclk),
      .mem_rdata (mem_rdata),
      .status    (status),
      .mem       (mem),
      .cfg       (cfg),
      .audio     (audio)
   );

   // asynchronous memory indexed by the low address bits
   assign mem_rdata = mem_model[mem.addr[7:0]];

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // console clock at one sixth of clk
   initial begin
      sysclk = 1'b0;
      forever begin
         repeat (3) @(posedge clk);
         #10;
         sysclk = ~sysclk;
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("timeout: the run did not complete in the expected time");
      $display("*** FAILED ***");
      $finish;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
      $display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
      mismatch_count++;
   endtask

   task automatic report_fault(input string what);
      $display("ERROR: %s", what);
      fault_count++;
   endtask

   //////////////////////////////////////////////////////////////////////
   // expected miso bytes
   //////////////////////////////////////////////////////////////////////

   // bit 8 set when byte k of the frame is predictable
   function automatic logic [8:0] ref_reply(input logic [7:0] cmd, input int k);
      logic [23:0] rd_addr;
      rd_addr = rd_base + 24'(k - 2);
      if (k == 0) begin
         return {1'b1, 8'h00};
      end else if (k == 1) begin
         // reply fetched during byte 0 still sees the previous command
         return 9'h000;
      end else if (cmd == cart_pkg::CMD_ECHO) begin
         return {1'b1, cart_pkg::ECHO_BYTE};
      end else if (cmd == cart_pkg::CMD_STATUS) begin
         if (k[0] == 1'b0) begin
            return {1'b1, status.dac_busy, status.msu_status[6], 6'b0};
         end
         return {1'b1, 2'b0, status.msu_status[5:0]};
      end else if (cmd == cart_pkg::CMD_PARAM_ECHO) begin
         if (k >= 3) begin
            return {1'b1, tx_bytes[k - 2]};
         end
         return 9'h000;
      end else if (cmd == cart_pkg::CMD_SYSCLK) begin
         // count bytes are checked as a range
         return (k == 2) ? 9'h100 : 9'h000;
      end else if (cmd[7:4] == cart_pkg::CMD_READ) begin
         return {1'b1, ref_mem[rd_addr[7:0]]};
      end
      return {1'b1, cmd};
   endfunction

   initial begin
      logic [8:0] expected;
      forever begin
         @(frame_done);
         for (int k = 0; k < frame_len; k++) begin
            expected = ref_reply(tx_bytes[0], k);
            if (expected[8] && rx_bytes[k] !== expected[7:0]) begin
               report_mismatch($sformatf("%s byte %0d", test_name, k), expected[7:0],
                               rx_bytes[k]);
            end
         end
      end
   end

   // memory strobes and the DAC reset and MSU status pulses
   always @(negedge clk) begin
      if (!reset) begin
         if (wr_n_prev && !mem.wr_n) begin
            if (!wr_active || wr_seen >= WR_BYTES) begin
               report_fault("write strobe outside a write frame");
            end else begin
               if (mem.addr !== wr_base + 24'(wr_seen)) begin
                  report_mismatch("write address", wr_base + 24'(wr_seen), mem.addr);
               end
               if (mem.wdata !== tx_bytes[wr_seen + 1]) begin
                  report_mismatch("write data", tx_bytes[wr_seen + 1], mem.wdata);
               end
               wr_seen++;
            end
            mem_model[mem.addr[7:0]] = mem.wdata;
         end
         if (rd_n_prev && !mem.rd_n) begin
            if (!rd_active) begin
               report_fault("read strobe outside a read frame");
            end else begin
               if (mem.addr !== rd_base + 24'(rd_seen)) begin
                  report_mismatch("read address", rd_base + 24'(rd_seen), mem.addr);
               end
               rd_seen++;
            end
         end
         if (audio.dac_reset && !dac_reset_prev) begin
            dac_reset_pulses++;
         end
         if (audio.msu_status_we && !msu_we_prev) begin
            msu_we_pulses++;
            msu_set_seen   = audio.msu_status_set;
            msu_reset_seen = audio.msu_status_reset;
         end
      end
      wr_n_prev      = mem.wr_n;
      rd_n_prev      = mem.rd_n;
      dac_reset_prev = audio.dac_reset;
      msu_we_prev    = audio.msu_status_we;
   end

   //////////////////////////////////////////////////////////////////////
   // SPI master in mode 0 with msb first
   //////////////////////////////////////////////////////////////////////

   // bytes right aligned with the first byte highest
   task automatic send_frame(input string name, input int len, input logic [127:0] bytes);
      test_name = name;
      frame_len = len;
      for (int b = 0; b < len; b++) begin
         tx_bytes[b] = bytes[(len - 1 - b) * 8 +: 8];
      end
      @(posedge clk);
      #10;
      ncs = 1'b0;
      for (int b = 0; b < len; b++) begin
         for (int i = 7; i >= 0; i--) begin
            mosi = tx_bytes[b][i];
            repeat (SCK_HALF) @(posedge clk);
            #10;
            rx_bytes[b][i] = miso;
            sck = 1'b1;
            repeat (SCK_HALF) @(posedge clk);
            #10;
            sck = 1'b0;
         end
      end
      repeat (SCK_HALF) @(posedge clk);
      #10;
      ncs  = 1'b1;
      mosi = 1'b0;
      repeat (16) @(posedge clk);
      -> frame_done;
      @(posedge clk);
      #10;
      frame_count++;
   endtask

   initial begin
      logic [127:0] pkt;
      logic [31:0]  freq;
      int           pulses_before;
      reset  = 1'b1;
      sck    = 1'b0;
      mosi   = 1'b0;
      ncs    = 1'b1;
      status = '{dac_busy: 1'b1, msu_status: 7'h5A};
      rd_base = '0;
      wr_base = 24'h3AC5FC;
      lcg_state = 32'hbecacf73;
      for (int a = 0; a < 256; a++) begin
         lcg_state    = lcg_next(lcg_state);
         mem_model[a] = lcg_state[23:16];
         ref_mem[a]   = lcg_state[23:16];
      end
      repeat (RESET_CYCLES) @(posedge clk);
      #10;
      reset = 1'b0;
      repeat (4) @(posedge clk);
      #10;

      send_frame("echo", 4, {8'hF0, 8'h11, 8'h22, 8'h33});
      send_frame("param echo", 6, {8'hFF, 8'h01, 8'h82, 8'h3C, 8'hD4, 8'h55});

      // configuration registers
      send_frame("mapper", 3, {8'h35, 8'h00, 8'h00});
      if (cfg.mapper !== 4'h5) begin
         report_mismatch("mapper", 4'h5, cfg.mapper);
      end
      send_frame("rom mask", 4, {8'h10, 8'h1F, 8'h7F, 8'hFE});
      if (cfg.rom_mask !== 24'h1F7FFE) begin
         report_mismatch("rom mask", 24'h1F7FFE, cfg.rom_mask);
      end
      send_frame("sram mask", 4, {8'h20, 8'h00, 8'h1F, 8'hFF});
      if (cfg.saveram_mask !== 24'h001FFF) begin
         report_mismatch("sram mask", 24'h001FFF, cfg.saveram_mask);
      end

      // write burst with auto-increment and a trailing byte for the last strobe
      send_frame("set addr", 4, {8'h00, wr_base});
      if (mem.addr !== wr_base) begin
         report_mismatch("set addr", wr_base, mem.addr);
      end
      pkt = 128'h98;
      for (int i = 0; i < WR_BYTES; i++) begin
         lcg_state = lcg_next(lcg_state);
         pkt = {pkt[119:0], lcg_state[15:8]};
         ref_mem[8'(wr_base + 24'(i))] = lcg_state[15:8];
      end
      pkt = {pkt[119:0], 8'h00};
      wr_active = 1'b1;
      send_frame("write", WR_BYTES + 2, pkt);
      wr_active = 1'b0;
      if (wr_seen != WR_BYTES) begin
         report_fault($sformatf("%0d write strobes seen, %0d expected", wr_seen, WR_BYTES));
      end
      for (int a = 0; a < 256; a++) begin
         if (mem_model[a] !== ref_mem[a]) begin
            report_mismatch($sformatf("memory %0h", a), ref_mem[a], mem_model[a]);
         end
      end

      // read back from the same start
      send_frame("set addr", 4, {8'h00, wr_base});
      rd_base = wr_base;
      rd_active = 1'b1;
      send_frame("read", WR_BYTES + 2, {8'h88, 72'h0});
      rd_active = 1'b0;
      // one read strobe for every byte after the command
      if (rd_seen != WR_BYTES + 1) begin
         report_fault($sformatf("%0d read strobes seen, %0d expected",
                                rd_seen, WR_BYTES + 1));
      end

      send_frame("dac addr", 3, {8'h01, 8'h05, 8'hA3});
      if (audio.dac_addr !== 11'h5A3) begin
         report_mismatch("dac addr", 11'h5A3, audio.dac_addr);
      end
      send_frame("msu addr", 3, {8'h02, 8'h2B, 8'h7C});
      if (audio.msu_addr !== 14'h2B7C) begin
         report_mismatch("msu addr", 14'h2B7C, audio.msu_addr);
      end

      send_frame("status", 4, {8'hF1, 24'h0});

      send_frame("dac play", 2, {8'hE2, 8'h00});
      if (audio.dac_play !== 1'b1) begin
         report_mismatch("dac play", 1'b1, audio.dac_play);
      end
      send_frame("dac pause", 2, {8'hE1, 8'h00});
      if (audio.dac_play !== 1'b0) begin
         report_mismatch("dac pause", 1'b0, audio.dac_play);
      end
      pulses_before = dac_reset_pulses;
      send_frame("dac reset", 2, {8'hE3, 8'h00});
      if (dac_reset_pulses != pulses_before + 1) begin
         report_mismatch("dac reset pulses", pulses_before + 1, dac_reset_pulses);
      end

      // set and reset bits land together with the we pulse
      pulses_before = msu_we_pulses;
      send_frame("msu status", 3, {8'hE0, 8'h2D, 8'h12});
      if (msu_we_pulses != pulses_before + 1) begin
         report_mismatch("msu we pulses", pulses_before + 1, msu_we_pulses);
      end
      if (msu_set_seen !== 6'h2D) begin
         report_mismatch("msu status set", 6'h2D, msu_set_seen);
      end
      if (msu_reset_seen !== 6'h12) begin
         report_mismatch("msu status reset", 6'h12, msu_reset_seen);
      end

      // let the meter finish full windows first
      repeat (2 * cart_pkg::FREQ_WINDOW) @(posedge clk);
      #10;
      send_frame("sysclk", 7, {8'hFE, 48'h0});
      freq = {rx_bytes[3], rx_bytes[4], rx_bytes[5], rx_bytes[6]};
      if (freq < FREQ_NOMINAL - 1 || freq > FREQ_NOMINAL + 1) begin
         report_mismatch("sysclk frequency", FREQ_NOMINAL, freq);
      end

      $display("frames %0d, mismatches %0d, other errors %0d, assertion failures %0d",
               frame_count, mismatch_count, fault_count, dut.u_assertions.fail_count);
      if (mismatch_count + fault_count + dut.u_assertions.fail_count == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// File: files.f
spi_link_pkg.sv
cart_pkg.sv
spi_slave.sv
clk_freq_meter.sv
mcu_cmd.sv
cart_ctrl_top.sv
cart_ctrl_assertions.sv
tb_cart_ctrl.sv

// File: Bender.yml
package:
  name: cart_ctrl

sources:
  - spi_link_pkg.sv
  - cart_pkg.sv
  - spi_slave.sv
  - clk_freq_meter.sv
  - mcu_cmd.sv
  - cart_ctrl_top.sv
  - target: test
    files:
      - cart_ctrl_assertions.sv
      - tb_cart_ctrl.sv
